//--- hdl/hack_consts.svh
`ifndef HACK_CONSTS_SVH
`define HACK_CONSTS_SVH

// System clocks per executed instruction
`define HACK_CPU_DIV 4

// Instruction ROM depth, indexed by low PC bits
`define HACK_ROM_WORDS  256
`define HACK_ROM_ADDR_W 8

// Data RAM depth, indexed by low address bits
`define HACK_RAM_WORDS  1024
`define HACK_RAM_ADDR_W 10

// Memory-mapped I/O registers
`define HACK_ADDR_LED  16'h6000
`define HACK_ADDR_UART 16'h6001

`endif

//--- hdl/hack_pkg.sv
package hack_pkg;

    // ALU control bits, in instruction order c1..c6
    typedef struct packed {
        logic zx;
        logic nx;
        logic zy;
        logic ny;
        logic f;
        logic no;
    } alu_ctrl_t;

    // Destination strobes d1..d3
    typedef struct packed {
        logic load_a;
        logic load_d;
        logic load_m;
    } dest_t;

    // A-instruction view: flag bit clear, 15-bit constant
    typedef struct packed {
        logic        is_c;
        logic [14:0] value;
    } a_instr_t;

    // C-instruction view: 111 a cccccc ddd jjj
    typedef struct packed {
        logic [2:0] prefix;
        logic       a;
        alu_ctrl_t  alu;
        dest_t      dest;
        logic       jlt;
        logic       jeq;
        logic       jgt;
    } c_instr_t;

    // One instruction word, decoded by its top bit
    typedef union packed {
        a_instr_t a_ins;
        c_instr_t c_ins;
    } hack_instr_u;

    // Data memory request from the CPU
    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] wdata;
        logic        we;
    } mem_bus_t;

endpackage

//--- hdl/hack_cpu_control.sv
`timescale 1ns/1ps
`include "hack_consts.svh"

module hack_cpu_control (
    input  logic                        clk_100mhz,
    input  logic                        rst_n,
    input  logic                        prog_valid,
    output logic                        prog_ready,
    input  hack_pkg::hack_instr_u       instr,
    input  logic                        busy,
    output logic                        rom_we,
    output logic [`HACK_ROM_ADDR_W-1:0] rom_waddr,
    output logic                        exec,
    output hack_pkg::alu_ctrl_t         alu_ctrl,
    output hack_pkg::dest_t             dest,
    output logic [2:0]                  jump_mask,
    output logic                        sel_a_const,
    output logic                        sel_m_operand
);
    localparam int DIV_W = (`HACK_CPU_DIV > 1) ? $clog2(`HACK_CPU_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`HACK_CPU_DIV - 1);
    localparam logic [`HACK_ROM_ADDR_W-1:0] LOAD_LAST = `HACK_ROM_ADDR_W'(`HACK_ROM_WORDS - 1);

    logic                        loading;
    logic [`HACK_ROM_ADDR_W-1:0] load_cnt;
    logic [DIV_W-1:0]            div_cnt;
    logic                        is_c;
    logic                        stall;

    // Load phase: one ROM word per accepted beat
    assign prog_ready = loading;
    assign rom_we     = loading & prog_valid;
    assign rom_waddr  = load_cnt;

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            loading  <= 1'b1;
            load_cnt <= '0;
        end else if (rom_we) begin
            load_cnt <= load_cnt + 1'b1;
            // Last word written, switch to run
            if (load_cnt == LOAD_LAST) begin
                loading <= 1'b0;
            end
        end
    end

    // Execute enable divider, parks on its last count during a stall
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (!loading) begin
            if (div_cnt != DIV_LAST) begin
                div_cnt <= div_cnt + 1'b1;
            end else if (!stall) begin
                div_cnt <= '0;
            end
        end
    end

    assign is_c = instr.a_ins.is_c;

    // Store to M while the UART holding register is still full
    assign stall = is_c & instr.c_ins.dest.load_m & busy;

    assign exec = !loading && (div_cnt == DIV_LAST) && !stall;

    // Instruction decode
    always_comb begin
        alu_ctrl      = instr.c_ins.alu;
        sel_a_const   = !is_c;
        sel_m_operand = is_c & instr.c_ins.a;
        if (is_c) begin
            dest      = instr.c_ins.dest;
            jump_mask = {instr.c_ins.jlt, instr.c_ins.jeq, instr.c_ins.jgt};
        end else begin
            // A-instruction only loads the constant into A
            dest      = '{load_a: 1'b1, load_d: 1'b0, load_m: 1'b0};
            jump_mask = 3'b000;
        end
    end

    // No instruction runs before the load counter has wrapped past the last ROM word
    a_no_exec_in_load: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        exec |-> load_cnt == '0);

    // ROM stays frozen once the CPU has started
    a_no_rom_we_in_run: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        !prog_ready |=> !rom_we && !prog_ready);

endmodule

//--- hdl/hack_alu.sv
`timescale 1ns/1ps

module hack_alu (
    input  logic [15:0]         x,
    input  logic [15:0]         y,
    input  hack_pkg::alu_ctrl_t ctrl,
    output logic [15:0]         result,
    output logic                zr,
    output logic                ng
);
    logic [15:0] x_z;
    logic [15:0] x_n;
    logic [15:0] y_z;
    logic [15:0] y_n;
    logic [15:0] f_out;

    // Zero then negate each operand
    assign x_z = ctrl.zx ? 16'h0000 : x;
    assign x_n = ctrl.nx ? ~x_z : x_z;
    assign y_z = ctrl.zy ? 16'h0000 : y;
    assign y_n = ctrl.ny ? ~y_z : y_z;

    // Add or bitwise AND
    assign f_out = ctrl.f ? (x_n + y_n) : (x_n & y_n);

    // Optional output negate
    assign result = ctrl.no ? ~f_out : f_out;

    // Status flags for jump evaluation
    assign zr = (result == 16'h0000);
    assign ng = result[15];

endmodule

//--- hdl/hack_regs.sv
`timescale 1ns/1ps

module hack_regs (
    input  logic                  clk_100mhz,
    input  logic                  rst_n,
    input  logic                  exec,
    input  hack_pkg::hack_instr_u instr,
    input  hack_pkg::dest_t       dest,
    input  logic [2:0]            jump_mask,
    input  logic                  sel_a_const,
    input  logic                  sel_m_operand,
    input  logic [15:0]           alu_result,
    input  logic                  zr,
    input  logic                  ng,
    input  logic [15:0]           in_m,
    output logic [15:0]           alu_x,
    output logic [15:0]           alu_y,
    output logic [14:0]           pc,
    output hack_pkg::mem_bus_t    bus
);
    logic [15:0] a_reg;
    logic [15:0] d_reg;
    logic        jump;

    // Operands: D on x, A or M on y
    assign alu_x = d_reg;
    assign alu_y = sel_m_operand ? in_m : a_reg;

    // Jump mask order is lt, eq, gt
    assign jump = (jump_mask[2] & ng) | (jump_mask[1] & zr) | (jump_mask[0] & ~zr & ~ng);

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            a_reg <= '0;
            d_reg <= '0;
            pc    <= '0;
        end else if (exec) begin
            if (dest.load_a) begin
                a_reg <= sel_a_const ? {1'b0, instr.a_ins.value} : alu_result;
            end
            if (dest.load_d) begin
                d_reg <= alu_result;
            end
            // Jump target is the A value before this instruction
            pc <= jump ? a_reg[14:0] : pc + 15'd1;
        end
    end

    // M address is the current A, write only on the executing clock
    assign bus.addr  = a_reg;
    assign bus.wdata = alu_result;
    assign bus.we    = exec & dest.load_m;

endmodule

//--- hdl/hack_rom.sv
`timescale 1ns/1ps
`include "hack_consts.svh"

module hack_rom (
    input  logic                        clk_100mhz,
    input  logic                        we,
    input  logic [`HACK_ROM_ADDR_W-1:0] waddr,
    input  logic [15:0]                 wdata,
    input  logic [14:0]                 pc,
    output hack_pkg::hack_instr_u       instr
);
    logic [15:0] mem [`HACK_ROM_WORDS];

    // Filled once by the program load stream
    always_ff @(posedge clk_100mhz) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Combinational fetch, upper PC bits ignored
    assign instr = mem[pc[`HACK_ROM_ADDR_W-1:0]];

endmodule

//--- hdl/hack_memory_io.sv
`timescale 1ns/1ps
`include "hack_consts.svh"

module hack_memory_io (
    input  logic               clk_100mhz,
    input  logic               rst_n,
    input  hack_pkg::mem_bus_t bus,
    output logic [15:0]        in_m,
    output logic               busy,
    output logic [1:0]         led,
    output logic               tx_valid,
    input  logic               tx_ready,
    output logic [7:0]         tx_data
);
    logic [15:0] ram [`HACK_RAM_WORDS];
    logic [`HACK_RAM_ADDR_W-1:0] ram_idx;
    logic is_led;
    logic is_uart;
    logic uart_we;

    assign ram_idx = bus.addr[`HACK_RAM_ADDR_W-1:0];
    assign is_led  = (bus.addr == `HACK_ADDR_LED);
    assign is_uart = (bus.addr == `HACK_ADDR_UART);
    assign uart_we = bus.we & is_uart;

    // Everything outside the two registers is RAM
    always_ff @(posedge clk_100mhz) begin
        if (bus.we && !is_led && !is_uart) begin
            ram[ram_idx] <= bus.wdata;
        end
    end

    always_comb begin
        if (is_led) begin
            in_m = {14'b0, led};
        end else if (is_uart) begin
            in_m = 16'h0000;
        end else begin
            in_m = ram[ram_idx];
        end
    end

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            led <= 2'b00;
        end else if (bus.we && is_led) begin
            led <= bus.wdata[1:0];
        end
    end

    // Holding register, refilled on the accept clock if a store is ready
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
        end else if (uart_we) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (uart_we) begin
            tx_data <= bus.wdata[7:0];
        end
    end

    // Byte still waiting and the CPU points at the UART register
    assign busy = tx_valid & ~tx_ready & is_uart;

    a_tx_hold: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

//--- hdl/hack_computer.sv
`timescale 1ns/1ps
`include "hack_consts.svh"

module hack_computer (
    input  logic        clk_100mhz,
    input  logic        rst_n,
    input  logic        prog_valid,
    output logic        prog_ready,
    input  logic [15:0] prog_data,
    output logic [1:0]  led,
    output logic        tx_valid,
    input  logic        tx_ready,
    output logic [7:0]  tx_data
);
    import hack_pkg::*;

    // CPU and memory
    hack_instr_u instr;
    mem_bus_t    bus;
    logic [14:0] pc;
    logic [15:0] in_m;
    logic        busy;

    // Control to datapath
    logic                        rom_we;
    logic [`HACK_ROM_ADDR_W-1:0] rom_waddr;
    logic                        exec;
    alu_ctrl_t                   alu_ctrl;
    dest_t                       dest;
    logic [2:0]                  jump_mask;
    logic                        sel_a_const;
    logic                        sel_m_operand;

    // ALU
    logic [15:0] alu_x;
    logic [15:0] alu_y;
    logic [15:0] alu_result;
    logic        zr;
    logic        ng;

    hack_cpu_control u_control (.clk_100mhz, .rst_n, .prog_valid, .prog_ready, .instr, .busy,
        .rom_we, .rom_waddr, .exec, .alu_ctrl, .dest, .jump_mask, .sel_a_const, .sel_m_operand);

    hack_alu u_alu (.x(alu_x), .y(alu_y), .ctrl(alu_ctrl), .result(alu_result), .zr, .ng);

    hack_regs u_regs (.clk_100mhz, .rst_n, .exec, .instr, .dest, .jump_mask, .sel_a_const,
        .sel_m_operand, .alu_result, .zr, .ng, .in_m, .alu_x, .alu_y, .pc, .bus);

    // Program words go straight into the ROM during loading
    hack_rom u_rom (.clk_100mhz, .we(rom_we), .waddr(rom_waddr), .wdata(prog_data), .pc, .instr);

    hack_memory_io u_mem_io (.clk_100mhz, .rst_n, .bus, .in_m, .busy, .led, .tx_valid,
        .tx_ready, .tx_data);

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    input  logic rst_req,
    output logic clk,
    output logic rst_n
);
    localparam int RESET_CYCLES = 16;

    logic rst_n_q = 1'b0;
    int   rst_cnt = 0;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Reset low for 16 falling edges after power-up or the last request
    always @(negedge clk or posedge rst_req) begin
        if (rst_req) begin
            rst_cnt <= 0;
            rst_n_q <= 1'b0;
        end else if (rst_cnt < RESET_CYCLES - 1) begin
            rst_cnt <= rst_cnt + 1;
        end else begin
            rst_n_q <= 1'b1;
        end
    end

    assign rst_n = rst_n_q;

endmodule

//--- testbench/tb_hack_computer.sv
`timescale 1ns/1ps
`include "hack_consts.svh"

module tb_hack_computer;
    import hack_pkg::*;

    localparam int HALT_ADDR    = `HACK_ROM_WORDS - 2;
    localparam int NUM_TESTS    = 3;
    localparam int QUIET_CYCLES = 200;

    logic        clk_100mhz;
    logic        rst_n;
    logic        rst_req = 1'b0;
    logic        prog_valid;
    logic        prog_ready;
    logic [15:0] prog_data;
    logic [1:0]  led;
    logic        tx_valid;
    logic        tx_ready;
    logic [7:0]  tx_data;

    // Program image and reference model state
    logic [15:0] prog [`HACK_ROM_WORDS];
    logic [15:0] ram_model [`HACK_RAM_WORDS];
    logic [7:0]  exp_bytes [$];
    logic [1:0]  exp_leds [$];
    int          model_steps;
    longint      cycle_count = 0;
    longint      cycle_limit = 100;
    string       test_name = "reset";

    tb_clock u_clock (.rst_req, .clk(clk_100mhz), .rst_n);

    hack_computer u_dut (.clk_100mhz, .rst_n, .prog_valid, .prog_ready, .prog_data, .led,
        .tx_valid, .tx_ready, .tx_data);

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string what, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAIL %s %s: expected 0x%02h, actual 0x%02h",
                test_name, what, expected, actual));
        end
    endtask

    task automatic check_led(input string what, input logic [1:0] expected,
                             input logic [1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAIL %s %s: expected %b, actual %b",
                test_name, what, expected, actual));
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        if (actual != expected) begin
            report_failure($sformatf("FAIL %s %s: expected %0d, actual %0d",
                test_name, what, expected, actual));
        end
    endtask

    // Watchdog, limit raised per test
    always @(posedge clk_100mhz) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_failure($sformatf("Timeout in %s after %0d cycles, DUT stopped making progress",
                test_name, cycle_count));
        end
    end

    function automatic logic [15:0] encode_a(input logic [14:0] value);
        hack_instr_u w;
        w.a_ins.is_c  = 1'b0;
        w.a_ins.value = value;
        return w;
    endfunction

    function automatic logic [15:0] encode_c(input logic a, input logic [5:0] comp,
                                             input logic [2:0] dest, input logic [2:0] jump);
        hack_instr_u w;
        w.c_ins.prefix = 3'b111;
        w.c_ins.a      = a;
        w.c_ins.alu    = comp;
        w.c_ins.dest   = dest;
        {w.c_ins.jlt, w.c_ins.jeq, w.c_ins.jgt} = jump;
        return w;
    endfunction

    // Hack ALU: zx nx zy ny f no
    function automatic logic [15:0] alu_model(input logic [15:0] x, input logic [15:0] y,
                                              input logic [5:0] c);
        logic [15:0] xs;
        logic [15:0] ys;
        logic [15:0] f;
        xs = c[5] ? 16'h0000 : x;
        xs = c[4] ? ~xs : xs;
        ys = c[3] ? 16'h0000 : y;
        ys = c[2] ? ~ys : ys;
        f  = c[1] ? xs + ys : xs & ys;
        return c[0] ? ~f : f;
    endfunction

    // One word that is safe to land on or skip, no M read and no jump
    function automatic logic [15:0] safe_word();
        if ($urandom % 2) begin
            return encode_a(15'($urandom));
        end
        return encode_c(1'b0, 6'($urandom), 3'($urandom), 3'b000);
    endfunction

    task automatic gen_program();
        int addr;
        int kind;
        int skip;
        logic [15:0] io_addr;
        addr = 0;
        // RAM 0..7 gets known values before any read
        for (int k = 0; k < 8; k++) begin
            prog[addr]     = encode_a(15'(k));
            prog[addr + 1] = encode_c(1'b0, 6'($urandom), 3'b001, 3'b000);
            addr += 2;
        end
        while (addr < HALT_ADDR) begin
            kind = (addr + 6 > HALT_ADDR) ? 0 : int'($urandom % 10);
            case (kind)
                0, 1: begin
                    prog[addr] = safe_word();
                    addr += 1;
                end
                2, 3, 4, 5, 6: begin
                    // UART writes dominate, then LED and RAM stores
                    io_addr = (kind <= 4) ? `HACK_ADDR_UART :
                              (kind == 5) ? `HACK_ADDR_LED : 16'($urandom % 8);
                    prog[addr]     = encode_a(15'(io_addr));
                    prog[addr + 1] = encode_c(1'($urandom), 6'($urandom),
                                              {1'b0, 1'($urandom), 1'b1}, 3'b000);
                    addr += 2;
                end
                7: begin
                    // M read from an initialized word or the LED register
                    io_addr = ($urandom % 9 == 8) ? `HACK_ADDR_LED : 16'($urandom % 8);
                    prog[addr]     = encode_a(15'(io_addr));
                    prog[addr + 1] = encode_c(1'b1, 6'($urandom), 3'($urandom), 3'b000);
                    addr += 2;
                end
                default: begin
                    // Forward jump over a few filler words to the next block
                    skip = 1 + int'($urandom % 4);
                    prog[addr]     = encode_a(15'(addr + 2 + skip));
                    prog[addr + 1] = encode_c(1'b0, 6'($urandom), {1'b0, 1'($urandom), 1'b0},
                                              3'($urandom));
                    for (int s = 0; s < skip; s++) begin
                        prog[addr + 2 + s] = safe_word();
                    end
                    addr += 2 + skip;
                end
            endcase
        end
        // Halt loop, 0;JMP back to its own A load
        prog[HALT_ADDR]     = encode_a(15'(HALT_ADDR));
        prog[HALT_ADDR + 1] = encode_c(1'b0, 6'b101010, 3'b000, 3'b111);
    endtask

    // Instruction-level model up to the halt loop
    task automatic run_model();
        logic [15:0] a_m;
        logic [15:0] d_m;
        logic [15:0] w;
        logic [15:0] y;
        logic [15:0] r;
        logic [1:0]  led_m;
        logic        jmp;
        int          pc_m;
        a_m = '0;
        d_m = '0;
        led_m = '0;
        pc_m = 0;
        model_steps = 0;
        exp_bytes.delete();
        exp_leds.delete();
        foreach (ram_model[i]) begin
            ram_model[i] = '0;
        end
        while (pc_m != HALT_ADDR) begin
            w = prog[pc_m];
            model_steps++;
            if (model_steps > `HACK_ROM_WORDS) begin
                report_failure("Generated program never reaches its halt loop");
            end
            if (!w[15]) begin
                a_m  = {1'b0, w[14:0]};
                pc_m = pc_m + 1;
            end else begin
                if (!w[12]) begin
                    y = a_m;
                end else if (a_m == `HACK_ADDR_LED) begin
                    y = {14'b0, led_m};
                end else if (a_m == `HACK_ADDR_UART) begin
                    y = 16'h0000;
                end else begin
                    y = ram_model[a_m[`HACK_RAM_ADDR_W-1:0]];
                end
                r   = alu_model(d_m, y, w[11:6]);
                jmp = (w[2] && r[15]) || (w[1] && r == 16'h0000) ||
                      (w[0] && !r[15] && r != 16'h0000);
                // Store goes to the address held before this instruction
                if (w[3]) begin
                    if (a_m == `HACK_ADDR_LED) begin
                        led_m = r[1:0];
                    end else if (a_m == `HACK_ADDR_UART) begin
                        exp_bytes.push_back(r[7:0]);
                        exp_leds.push_back(led_m);
                    end else begin
                        ram_model[a_m[`HACK_RAM_ADDR_W-1:0]] = r;
                    end
                end
                pc_m = jmp ? int'(a_m[14:0]) : pc_m + 1;
                if (w[5]) begin
                    a_m = r;
                end
                if (w[4]) begin
                    d_m = r;
                end
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk_100mhz);
        rst_req <= 1'b1;
        @(negedge clk_100mhz);
        rst_req <= 1'b0;
        while (rst_n !== 1'b1) begin
            @(negedge clk_100mhz);
        end
        @(negedge clk_100mhz);
        check_led("led after reset", 2'b00, led);
        if (prog_ready !== 1'b1) begin
            report_failure("prog_ready is not high after reset");
        end
        if (tx_valid !== 1'b0) begin
            report_failure("tx_valid is not low after reset");
        end
    endtask

    // Gapped valid, a beat counts when valid meets ready at the next rising edge
    task automatic load_program();
        int idx;
        idx = 0;
        while (idx < `HACK_ROM_WORDS) begin
            @(negedge clk_100mhz);
            if (prog_ready !== 1'b1) begin
                report_failure($sformatf("prog_ready dropped after only %0d words", idx));
            end
            if (tx_valid !== 1'b0) begin
                report_failure("tx_valid rose while the program was loading");
            end
            tx_ready   = 1'($urandom);
            prog_valid = ($urandom % 3) != 0;
            prog_data  = prog_valid ? prog[idx] : 16'($urandom);
            if (prog_valid) begin
                idx++;
            end
        end
        @(negedge clk_100mhz);
        prog_valid = 1'b0;
        if (prog_ready !== 1'b0) begin
            report_failure("prog_ready still high after all ROM words were accepted");
        end
    endtask

    task automatic collect_bytes();
        int         rx;
        int         quiet;
        logic       prev_valid;
        logic       prev_xfer;
        logic [7:0] prev_data;
        logic [1:0] led_at_load;
        rx = 0;
        quiet = 0;
        prev_valid = 1'b0;
        prev_xfer = 1'b0;
        prev_data = '0;
        led_at_load = '0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge clk_100mhz);
            tx_ready = 1'($urandom);
            if (tx_valid === 1'b1) begin
                if (!prev_valid || prev_xfer) begin
                    if (rx >= exp_bytes.size()) begin
                        check_count("transmit bytes", exp_bytes.size(), rx + 1);
                    end
                    // LED holds on the clock that loaded this byte
                    led_at_load = led;
                end else begin
                    check_byte("tx_data while waiting", prev_data, tx_data);
                end
                if (tx_ready) begin
                    check_byte($sformatf("byte %0d", rx), exp_bytes[rx], tx_data);
                    check_led($sformatf("led at byte %0d", rx), exp_leds[rx], led_at_load);
                    rx++;
                end
            end else if (prev_valid && !prev_xfer) begin
                report_failure("tx_valid dropped before the byte was accepted");
            end
            prev_valid = (tx_valid === 1'b1);
            prev_xfer  = prev_valid && tx_ready;
            prev_data  = tx_data;
            if (rx == exp_bytes.size()) begin
                quiet++;
            end
        end
    endtask

    initial begin
        int unsigned seed_ret;
        prog_valid = 1'b0;
        prog_data  = '0;
        tx_ready   = 1'b0;
        seed_ret   = $urandom(32'h0b99ccbc);
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_name = $sformatf("program_%0d", t);
            gen_program();
            run_model();
            // Reset, gapped load, stalled execution, quiet window, slack
            cycle_limit = cycle_count + 40 + 8 * `HACK_ROM_WORDS +
                          model_steps * `HACK_CPU_DIV * 4 + QUIET_CYCLES + 200;
            apply_reset();
            load_program();
            collect_bytes();
            $display("%s: %0d bytes over %0d instructions", test_name, exp_bytes.size(),
                     model_steps);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- files.f
+incdir+hdl
hdl/hack_pkg.sv
hdl/hack_cpu_control.sv
hdl/hack_alu.sv
hdl/hack_regs.sv
hdl/hack_rom.sv
hdl/hack_memory_io.sv
hdl/hack_computer.sv
testbench/tb_clock.sv
testbench/tb_hack_computer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Hack computer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module tb_hack_computer -o sim_hack

./obj_dir/sim_hack 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi
grep -q "Simulation PASSED" sim.log
echo "Run passed"
